// File: project.f
source/issue_pkg.sv
source/gpr_file.sv
source/scoreboard.sv
source/issue_unit.sv
source/commit_unit.sv
source/issue_stage.sv
verification/issue_stage_tb.sv

// File: run.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and checks the log.
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module issue_stage_tb \
  -f project.f -o issue_stage_sim

./obj_dir/issue_stage_sim | tee sim.log

if grep -q "Verification passed" sim.log; then
  echo "Simulation run succeeded."
else
  echo "Simulation run reported failure."
  exit 1
fi

// File: verification/issue_stage_tb.sv
`timescale 1ns/100ps

module issue_stage_tb;

  localparam int num_uops       = 400;
  localparam int cycles_per_uop = 20;
  localparam int clock_period   = 8;

  // One result waiting in a functional unit.
  typedef struct packed {
    logic [issue_pkg::tag_width-1:0] tag;
    logic [issue_pkg::xlen-1:0]      data;
    int                              due;   // Cycle from which it may be written back.
  } pending_t;

  logic                                           clock;
  logic                                           arst_n;
  issue_pkg::uop_t                                idu_uop;
  logic                                           idu_valid;
  logic                                           idu_ready;
  logic                                           flush_unissued;
  issue_pkg::fu_req_t                             fu_req;
  logic                                           alu_ready;
  logic                                           mdu_ready;
  logic                                           lsu_ready;
  logic                                           alu_valid;
  logic                                           mdu_valid;
  logic                                           lsu_valid;
  issue_pkg::writeback_t [issue_pkg::wb_ports-1:0] wb;
  logic                                           retire_valid;
  issue_pkg::retire_t                             retire;

  logic [issue_pkg::xlen-1:0] model_regs [32];
  issue_pkg::uop_t            accepted_q [$];
  issue_pkg::retire_t         retire_q [$];
  pending_t                   pending_q [$];
  pending_t                   kept_q [$];
  issue_pkg::fu_req_t         prev_req;
  logic                       prev_held;
  logic                       prev_quiet;
  logic                       held_now;
  logic                       dispatch_now;
  logic                       accepted_now;
  logic                       running;
  logic [issue_pkg::xlen-1:0] next_pc;
  int cycle = 0;
  int n_sent = 0;
  int n_accepted = 0;
  int n_retired = 0;
  int n_flushed = 0;
  int in_flight = 0;
  int value_errors = 0;
  int protocol_errors = 0;

  issue_stage issue_stage_i (
    .clock          (clock),
    .arst_n         (arst_n),
    .idu_uop        (idu_uop),
    .idu_valid      (idu_valid),
    .idu_ready      (idu_ready),
    .flush_unissued (flush_unissued),
    .fu_req         (fu_req),
    .alu_ready      (alu_ready),
    .mdu_ready      (mdu_ready),
    .lsu_ready      (lsu_ready),
    .alu_valid      (alu_valid),
    .mdu_valid      (mdu_valid),
    .lsu_valid      (lsu_valid),
    .wb             (wb),
    .retire_valid   (retire_valid),
    .retire         (retire)
  );

  // Operation of every emulated unit, selected by op alone.
  function automatic logic [issue_pkg::xlen-1:0] unit_result(
    input logic [3:0]                op,
    input logic [issue_pkg::xlen-1:0] a,
    input logic [issue_pkg::xlen-1:0] b,
    input logic [issue_pkg::xlen-1:0] imm
  );
    case (op)
      4'd0:    return a + b;
      4'd1:    return a - b;
      4'd2:    return a ^ b;
      4'd3:    return a | b;
      4'd4:    return a & b;
      4'd5:    return a + imm;
      4'd6:    return a << b[4:0];
      4'd7:    return a >> b[4:0];
      4'd8:    return a * b;
      4'd9:    return b + imm;
      4'd10:   return ~a;
      4'd11:   return imm;
      4'd12:   return a ^ imm;
      4'd13:   return (a < b) ? 32'd1 : 32'd0;
      4'd14:   return a + b + imm;
      default: return a - imm;
    endcase
  endfunction

  function automatic issue_pkg::uop_t random_uop(input logic [issue_pkg::xlen-1:0] pc);
    issue_pkg::uop_t u;
    u.pc      = pc;
    u.fu      = issue_pkg::fu_e'(2'($urandom_range(0, 2)));
    u.op      = 4'($urandom_range(0, 15));
    u.rs1     = 5'($urandom_range(0, 7)); // A small window keeps hazards frequent.
    u.rs2     = 5'($urandom_range(0, 7));
    u.rd      = 5'($urandom_range(0, 7));
    u.use_rs1 = $urandom_range(0, 3) != 0;
    u.use_rs2 = $urandom_range(0, 3) != 0;
    u.we      = $urandom_range(0, 9) < 8;
    u.imm     = $urandom;
    return u;
  endfunction

  function automatic logic writer_in_flight(input logic [issue_pkg::reg_addr_width-1:0] rs);
    foreach (retire_q[i]) begin
      if (retire_q[i].we && retire_q[i].rd == rs && rs != '0) begin
        return 1'b1;
      end
    end
    return 1'b0;
  endfunction

  // With no writer in flight the operands come from the register file and cannot move.
  function automatic logic quiet_operands(input issue_pkg::uop_t u);
    return !(u.use_rs1 && writer_in_flight(u.rs1)) && !(u.use_rs2 && writer_in_flight(u.rs2));
  endfunction

  function automatic issue_pkg::fu_req_t static_view(input issue_pkg::fu_req_t req);
    issue_pkg::fu_req_t v;
    v          = req;
    v.rs1_data = '0;
    v.rs2_data = '0;
    return v;
  endfunction

  function automatic int pick_free_port(
    input issue_pkg::writeback_t [issue_pkg::wb_ports-1:0] ports
  );
    int free_idx [$];
    for (int p = 0; p < issue_pkg::wb_ports; p++) begin
      if (!ports[p].valid) begin
        free_idx.push_back(p);
      end
    end
    if (free_idx.size() == 0) begin
      return -1;
    end
    return free_idx[$urandom_range(0, free_idx.size() - 1)];
  endfunction

  task automatic value_error(
    input string       what,
    input logic [31:0] expected,
    input logic [31:0] got
  );
    $display("[FAIL] %0t ns: %s expected %h, got %h", $time, what, expected, got);
    value_errors++;
  endtask

  task automatic protocol_error(input string what);
    $display("Protocol error at %0t ns: %s", $time, what);
    protocol_errors++;
  endtask

  task automatic check_idle(input string when);
    if (!idu_ready) protocol_error({"idu_ready is low ", when});
    if (alu_valid || mdu_valid || lsu_valid) protocol_error({"a unit valid is high ", when});
    if (retire_valid) protocol_error({"retire_valid is high ", when});
  endtask

  // Executes the oldest accepted uop on the model and hands the request to its unit.
  task automatic check_dispatch();
    issue_pkg::uop_t            u;
    issue_pkg::retire_t         r;
    pending_t                   p;
    logic [issue_pkg::xlen-1:0] exp_a;
    logic [issue_pkg::xlen-1:0] exp_b;
    if (accepted_q.size() == 0) begin
      protocol_error("a unit valid rose with no accepted micro-op held");
      return;
    end
    u     = accepted_q.pop_front();
    exp_a = u.use_rs1 ? model_regs[u.rs1] : '0;
    exp_b = u.use_rs2 ? model_regs[u.rs2] : '0;
    if (fu_req.pc !== u.pc) value_error("fu_req.pc", u.pc, fu_req.pc);
    if (fu_req.fu !== u.fu) value_error("fu_req.fu", 32'(u.fu), 32'(fu_req.fu));
    if (fu_req.op !== u.op) value_error("fu_req.op", 32'(u.op), 32'(fu_req.op));
    if (fu_req.imm !== u.imm) value_error("fu_req.imm", u.imm, fu_req.imm);
    if (fu_req.rs1_data !== exp_a) value_error("fu_req.rs1_data", exp_a, fu_req.rs1_data);
    if (fu_req.rs2_data !== exp_b) value_error("fu_req.rs2_data", exp_b, fu_req.rs2_data);
    r.pc    = u.pc;
    r.rd    = u.rd;
    r.we    = u.we;
    r.wdata = unit_result(u.op, exp_a, exp_b, u.imm);
    if (u.we && u.rd != '0) begin
      model_regs[u.rd] = r.wdata;
    end
    retire_q.push_back(r);
    p.tag  = fu_req.tag;
    p.data = unit_result(fu_req.op, fu_req.rs1_data, fu_req.rs2_data, fu_req.imm);
    p.due  = cycle + int'($urandom_range(1, 6));
    pending_q.push_back(p);
    in_flight++;
  endtask

  // Every retirement the stage reports is counted, expected or not.
  task automatic check_retire();
    issue_pkg::retire_t r;
    n_retired++;
    if (retire_q.size() == 0) begin
      protocol_error("retire_valid is high with nothing in flight");
      return;
    end
    r = retire_q.pop_front();
    if (retire.pc !== r.pc) value_error("retire.pc", r.pc, retire.pc);
    if (retire.rd !== r.rd) value_error("retire.rd", 32'(r.rd), 32'(retire.rd));
    if (retire.we !== r.we) value_error("retire.we", 32'(r.we), 32'(retire.we));
    if (retire.wdata !== r.wdata) value_error("retire.wdata", r.wdata, retire.wdata);
    in_flight--;
  endtask

  task automatic drive_writebacks();
    issue_pkg::writeback_t [issue_pkg::wb_ports-1:0] wb_next;
    int port;
    wb_next = '0;
    kept_q.delete();
    foreach (pending_q[i]) begin
      port = pick_free_port(wb_next);
      if (pending_q[i].due <= cycle && port >= 0) begin
        wb_next[port].valid = 1'b1;
        wb_next[port].tag   = pending_q[i].tag;
        wb_next[port].data  = pending_q[i].data;
      end else begin
        kept_q.push_back(pending_q[i]);
      end
    end
    pending_q = kept_q;
    wb <= wb_next;
  endtask

  initial begin
    clock = 1'b0;
    forever #(clock_period / 2) clock = ~clock;
  end

  // Decoder, unit readies and writebacks change only at rising edges.
  always @(posedge clock) begin
    if (running) begin
      cycle++;
      alu_ready      <= $urandom_range(0, 99) < 70;
      mdu_ready      <= $urandom_range(0, 99) < 50;
      lsu_ready      <= $urandom_range(0, 99) < 60;
      flush_unissued <= $urandom_range(0, 99) < 3;
      if (!idu_valid || accepted_now) begin
        if (n_sent < num_uops && $urandom_range(0, 99) < 80) begin
          idu_uop   <= random_uop(next_pc);
          idu_valid <= 1'b1;
          next_pc = next_pc + 32'd4;
          n_sent++;
        end else begin
          idu_valid <= 1'b0;
        end
      end
      drive_writebacks();
    end
  end

  // Samples at the falling edge what the next rising edge will transfer.
  always @(negedge clock) begin
    accepted_now = 1'b0;
    held_now     = accepted_q.size() != 0;
    dispatch_now = (alu_valid && alu_ready) || (mdu_valid && mdu_ready) ||
                   (lsu_valid && lsu_ready);
    if (alu_valid && !alu_ready) protocol_error("alu_valid is high while alu_ready is low");
    if (mdu_valid && !mdu_ready) protocol_error("mdu_valid is high while mdu_ready is low");
    if (lsu_valid && !lsu_ready) protocol_error("lsu_valid is high while lsu_ready is low");
    if ($countones({alu_valid, mdu_valid, lsu_valid}) > 1) begin
      protocol_error("more than one unit valid is high");
    end
    if (held_now &&
        ((alu_valid && accepted_q[0].fu != issue_pkg::fu_alu) ||
         (mdu_valid && accepted_q[0].fu != issue_pkg::fu_mdu) ||
         (lsu_valid && accepted_q[0].fu != issue_pkg::fu_lsu))) begin
      protocol_error("a unit valid does not match the unit of the held micro-op");
    end
    if (flush_unissued && (dispatch_now || idu_ready)) begin
      protocol_error("the stage dispatched or accepted during a flush");
    end
    if (prev_held && held_now) begin
      if (prev_quiet ? (fu_req !== prev_req) : (static_view(fu_req) !== static_view(prev_req))) begin
        protocol_error("fu_req changed while the micro-op waited for dispatch");
      end
    end
    prev_held  = held_now && !dispatch_now && !flush_unissued;
    prev_quiet = 1'b0;
    if (prev_held) begin
      prev_quiet = quiet_operands(accepted_q[0]);
    end
    prev_req = fu_req;
    if (retire_valid) check_retire();
    if (flush_unissued) begin
      n_flushed += accepted_q.size(); // The held uop is dropped unissued.
      accepted_q.delete();
    end else if (dispatch_now) begin
      check_dispatch();
    end
    if (in_flight > issue_pkg::sb_depth) protocol_error("more micro-ops in flight than entries");
    if (idu_valid && idu_ready) begin
      accepted_q.push_back(idu_uop);
      n_accepted++;
      accepted_now = 1'b1;
      if (accepted_q.size() > 1) protocol_error("a micro-op was accepted over a held one");
    end
  end

  initial begin
    void'($urandom(32'hdf6c_ae55));
    arst_n         = 1'b0;
    idu_uop        = '0;
    idu_valid      = 1'b0;
    flush_unissued = 1'b0;
    alu_ready      = 1'b0;
    mdu_ready      = 1'b0;
    lsu_ready      = 1'b0;
    wb             = '0;
    running        = 1'b0;
    accepted_now   = 1'b0;
    prev_held      = 1'b0;
    prev_quiet     = 1'b0;
    next_pc        = 32'h0000_1000;
    foreach (model_regs[i]) begin
      model_regs[i] = '0;
    end
    repeat (2) @(posedge clock);
    @(negedge clock);
    check_idle("during reset");
    @(posedge clock);
    arst_n <= 1'b1;
    @(negedge clock);
    check_idle("after reset");
    running = 1'b1;
    while (n_sent < num_uops || idu_valid || accepted_q.size() != 0 || retire_q.size() != 0) begin
      @(negedge clock);
    end
    repeat (10) @(negedge clock);
    if (n_retired + n_flushed != num_uops) begin
      protocol_error("retired plus flushed micro-ops do not add up to the number sent");
    end
    $display("Errors: %0d value, %0d protocol; %0d accepted, %0d retired, %0d flushed",
             value_errors, protocol_errors, n_accepted, n_retired, n_flushed);
    if (value_errors + protocol_errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

  initial begin
    #(num_uops * cycles_per_uop * clock_period);
    $display("Timeout: the run did not finish within %0d cycles", num_uops * cycles_per_uop);
    $display("Verification failed");
    $finish;
  end

endmodule

// File: source/issue_stage.sv
`timescale 1ns/100ps

module issue_stage (
  input  logic                                       clock,
  input  logic                                       arst_n,
  input  issue_pkg::uop_t                            idu_uop,
  input  logic                                       idu_valid,
  output logic                                       idu_ready,
  input  logic                                       flush_unissued,
  output issue_pkg::fu_req_t                         fu_req,
  input  logic                                       alu_ready,
  input  logic                                       mdu_ready,
  input  logic                                       lsu_ready,
  output logic                                       alu_valid,
  output logic                                       mdu_valid,
  output logic                                       lsu_valid,
  input  issue_pkg::writeback_t [issue_pkg::wb_ports-1:0] wb,
  output logic                                       retire_valid,
  output issue_pkg::retire_t                         retire
);

  issue_pkg::operand_t                  rs1_op;
  issue_pkg::operand_t                  rs2_op;
  issue_pkg::sb_entry_t                 head;
  logic                                 head_valid;
  logic                                 free_head;
  logic                                 sb_full;
  logic                                 alloc;
  logic [issue_pkg::tag_width-1:0]      alloc_tag;
  logic [issue_pkg::reg_addr_width-1:0] alloc_rd;
  logic                                 alloc_we;
  logic [issue_pkg::reg_addr_width-1:0] gpr_raddr_a;
  logic [issue_pkg::reg_addr_width-1:0] gpr_raddr_b;
  logic [issue_pkg::xlen-1:0]           gpr_rdata_a;
  logic [issue_pkg::xlen-1:0]           gpr_rdata_b;
  logic                                 gpr_we;
  logic [issue_pkg::reg_addr_width-1:0] gpr_waddr;
  logic [issue_pkg::xlen-1:0]           gpr_wdata;

  gpr_file gpr_file_i (
    .clock   (clock),
    .arst_n  (arst_n),
    .raddr_a (gpr_raddr_a),
    .raddr_b (gpr_raddr_b),
    .we      (gpr_we),
    .waddr   (gpr_waddr),
    .wdata   (gpr_wdata),
    .rdata_a (gpr_rdata_a),
    .rdata_b (gpr_rdata_b)
  );

  // The scoreboard looks up the same registers the file is reading.
  scoreboard scoreboard_i (
    .clock      (clock),
    .arst_n     (arst_n),
    .alloc      (alloc),
    .alloc_rd   (alloc_rd),
    .alloc_we   (alloc_we),
    .alloc_pc   (fu_req.pc),
    .wb         (wb),
    .rs1        (gpr_raddr_a),
    .rs2        (gpr_raddr_b),
    .free_head  (free_head),
    .alloc_tag  (alloc_tag),
    .sb_full    (sb_full),
    .rs1_op     (rs1_op),
    .rs2_op     (rs2_op),
    .head       (head),
    .head_valid (head_valid)
  );

  issue_unit issue_unit_i (
    .clock          (clock),
    .arst_n         (arst_n),
    .idu_uop        (idu_uop),
    .idu_valid      (idu_valid),
    .flush_unissued (flush_unissued),
    .rs1_op         (rs1_op),
    .rs2_op         (rs2_op),
    .gpr_rdata_a    (gpr_rdata_a),
    .gpr_rdata_b    (gpr_rdata_b),
    .sb_full        (sb_full),
    .alloc_tag      (alloc_tag),
    .alu_ready      (alu_ready),
    .mdu_ready      (mdu_ready),
    .lsu_ready      (lsu_ready),
    .idu_ready      (idu_ready),
    .fu_req         (fu_req),
    .alu_valid      (alu_valid),
    .mdu_valid      (mdu_valid),
    .lsu_valid      (lsu_valid),
    .alloc          (alloc),
    .alloc_rd       (alloc_rd),
    .alloc_we       (alloc_we),
    .gpr_raddr_a    (gpr_raddr_a),
    .gpr_raddr_b    (gpr_raddr_b)
  );

  commit_unit commit_unit_i (
    .head         (head),
    .head_valid   (head_valid),
    .free_head    (free_head),
    .gpr_we       (gpr_we),
    .gpr_waddr    (gpr_waddr),
    .gpr_wdata    (gpr_wdata),
    .retire_valid (retire_valid),
    .retire       (retire)
  );

endmodule

// File: source/commit_unit.sv
`timescale 1ns/100ps

module commit_unit (
  input  issue_pkg::sb_entry_t                 head,
  input  logic                                 head_valid,
  output logic                                 free_head,
  output logic                                 gpr_we,
  output logic [issue_pkg::reg_addr_width-1:0] gpr_waddr,
  output logic [issue_pkg::xlen-1:0]           gpr_wdata,
  output logic                                 retire_valid,
  output issue_pkg::retire_t                   retire
);

  logic commit;

  // Only the oldest entry may leave, and only once it is done.
  assign commit = head_valid && head.done;

  assign free_head    = commit;
  assign retire_valid = commit;

  // A retiring write to x0 never reaches the register file.
  assign gpr_we    = commit && head.we && head.rd != '0;
  assign gpr_waddr = head.rd;
  assign gpr_wdata = head.data;

  always_comb begin
    retire.pc    = head.pc;
    retire.rd    = head.rd;
    retire.we    = head.we;
    retire.wdata = head.data;
  end

endmodule

// File: source/issue_unit.sv
`timescale 1ns/100ps

module issue_unit (
  input  logic                                 clock,
  input  logic                                 arst_n,
  input  issue_pkg::uop_t                      idu_uop,
  input  logic                                 idu_valid,
  input  logic                                 flush_unissued,
  input  issue_pkg::operand_t                  rs1_op,
  input  issue_pkg::operand_t                  rs2_op,
  input  logic [issue_pkg::xlen-1:0]           gpr_rdata_a,
  input  logic [issue_pkg::xlen-1:0]           gpr_rdata_b,
  input  logic                                 sb_full,
  input  logic [issue_pkg::tag_width-1:0]      alloc_tag,
  input  logic                                 alu_ready,
  input  logic                                 mdu_ready,
  input  logic                                 lsu_ready,
  output logic                                 idu_ready,
  output issue_pkg::fu_req_t                   fu_req,
  output logic                                 alu_valid,
  output logic                                 mdu_valid,
  output logic                                 lsu_valid,
  output logic                                 alloc,
  output logic [issue_pkg::reg_addr_width-1:0] alloc_rd,
  output logic                                 alloc_we,
  output logic [issue_pkg::reg_addr_width-1:0] gpr_raddr_a,
  output logic [issue_pkg::reg_addr_width-1:0] gpr_raddr_b
);

  issue_pkg::uop_t            held;
  logic                       held_valid;
  logic                       operand_busy;
  logic                       unit_ready;
  logic                       can_issue;
  logic                       dispatch;
  logic                       accept;
  logic [issue_pkg::xlen-1:0] op_a;
  logic [issue_pkg::xlen-1:0] op_b;

  assign gpr_raddr_a = held.rs1;
  assign gpr_raddr_b = held.rs2;

  // Forwarded data takes precedence over the register file.
  assign op_a = !held.use_rs1 ? '0 : (rs1_op.hit ? rs1_op.data : gpr_rdata_a);
  assign op_b = !held.use_rs2 ? '0 : (rs2_op.hit ? rs2_op.data : gpr_rdata_b);

  assign operand_busy = (held.use_rs1 && rs1_op.busy) || (held.use_rs2 && rs2_op.busy);

  always_comb begin
    case (held.fu)
      issue_pkg::fu_alu: unit_ready = alu_ready;
      issue_pkg::fu_mdu: unit_ready = mdu_ready;
      issue_pkg::fu_lsu: unit_ready = lsu_ready;
      default:           unit_ready = 1'b0;
    endcase
  end

  // A flush in this cycle wins over both dispatch and acceptance.
  assign can_issue = held_valid && !operand_busy && !sb_full && !flush_unissued;
  assign dispatch  = can_issue && unit_ready;
  assign idu_ready = (!held_valid || dispatch) && !flush_unissued;
  assign accept    = idu_valid && idu_ready;

  assign alu_valid = dispatch && held.fu == issue_pkg::fu_alu;
  assign mdu_valid = dispatch && held.fu == issue_pkg::fu_mdu;
  assign lsu_valid = dispatch && held.fu == issue_pkg::fu_lsu;

  assign alloc    = dispatch;
  assign alloc_rd = held.rd;
  assign alloc_we = held.we;

  always_comb begin
    fu_req.tag      = alloc_tag;
    fu_req.fu       = held.fu;
    fu_req.op       = held.op;
    fu_req.rs1_data = op_a;
    fu_req.rs2_data = op_b;
    fu_req.imm      = held.imm;
    fu_req.pc       = held.pc;
  end

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      held_valid <= 1'b0;
    end else if (flush_unissued) begin
      held_valid <= 1'b0;
    end else if (accept) begin
      held_valid <= 1'b1;
    end else if (dispatch) begin
      held_valid <= 1'b0;
    end
  end

  always_ff @(posedge clock) begin
    if (accept) begin
      held <= idu_uop;
    end
  end

endmodule

// File: source/scoreboard.sv
`timescale 1ns/100ps

module scoreboard (
  input  logic                                       clock,
  input  logic                                       arst_n,
  input  logic                                       alloc,
  input  logic [issue_pkg::reg_addr_width-1:0]       alloc_rd,
  input  logic                                       alloc_we,
  input  logic [issue_pkg::xlen-1:0]                 alloc_pc,
  input  issue_pkg::writeback_t [issue_pkg::wb_ports-1:0] wb,
  input  logic [issue_pkg::reg_addr_width-1:0]       rs1,
  input  logic [issue_pkg::reg_addr_width-1:0]       rs2,
  input  logic                                       free_head,
  output logic [issue_pkg::tag_width-1:0]            alloc_tag,
  output logic                                       sb_full,
  output issue_pkg::operand_t                        rs1_op,
  output issue_pkg::operand_t                        rs2_op,
  output issue_pkg::sb_entry_t                       head,
  output logic                                       head_valid
);

  issue_pkg::sb_entry_t                  entries [issue_pkg::sb_depth];
  logic [issue_pkg::tag_width-1:0]       head_ptr;
  logic [issue_pkg::tag_width-1:0]       tail_ptr;
  logic [issue_pkg::sb_count_width-1:0]  count;

  assign alloc_tag  = tail_ptr; // The entry index doubles as the tag.
  assign sb_full    = (count == issue_pkg::sb_depth);
  assign head       = entries[head_ptr];
  assign head_valid = entries[head_ptr].valid;

  // Pointers and occupancy.
  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      head_ptr <= '0;
      tail_ptr <= '0;
      count    <= '0;
    end else begin
      if (alloc) begin
        tail_ptr <= tail_ptr + 1'b1;
      end
      if (free_head) begin
        head_ptr <= head_ptr + 1'b1;
      end
      case ({alloc, free_head})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Entries are filled at the tail, completed by tag and released at the head.
  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < issue_pkg::sb_depth; i++) begin
        entries[i].valid <= 1'b0;
        entries[i].done  <= 1'b0;
      end
    end else begin
      // A done head is never the target of a writeback, and a full table
      // blocks allocation, so these updates never touch the same entry.
      if (free_head) begin
        entries[head_ptr].valid <= 1'b0;
      end
      for (int p = 0; p < issue_pkg::wb_ports; p++) begin
        if (wb[p].valid) begin
          entries[wb[p].tag].done <= 1'b1;
          entries[wb[p].tag].data <= wb[p].data;
        end
      end
      if (alloc) begin
        entries[tail_ptr].valid <= 1'b1;
        entries[tail_ptr].done  <= 1'b0;
        entries[tail_ptr].rd    <= alloc_rd;
        entries[tail_ptr].we    <= alloc_we;
        entries[tail_ptr].pc    <= alloc_pc;
      end
    end
  end

  // Walks from the head towards the tail, so the youngest writer wins.
  function automatic issue_pkg::operand_t lookup(
    input logic [issue_pkg::reg_addr_width-1:0] rs
  );
    issue_pkg::operand_t             res;
    issue_pkg::sb_entry_t            e;
    logic [issue_pkg::tag_width-1:0] idx;
    res = '0;
    for (int i = 0; i < issue_pkg::sb_depth; i++) begin
      idx = head_ptr + i[issue_pkg::tag_width-1:0];
      e   = entries[idx];
      if (e.valid && e.we && e.rd == rs && rs != '0) begin
        res.busy = !e.done;
        res.hit  = e.done;
        res.data = e.data;
      end
    end
    return res;
  endfunction

  always_comb begin
    rs1_op = lookup(rs1);
    rs2_op = lookup(rs2);
  end

endmodule

// File: source/gpr_file.sv
`timescale 1ns/100ps

module gpr_file (
  input  logic                                 clock,
  input  logic                                 arst_n,
  input  logic [issue_pkg::reg_addr_width-1:0] raddr_a,
  input  logic [issue_pkg::reg_addr_width-1:0] raddr_b,
  input  logic                                 we,
  input  logic [issue_pkg::reg_addr_width-1:0] waddr,
  input  logic [issue_pkg::xlen-1:0]           wdata,
  output logic [issue_pkg::xlen-1:0]           rdata_a,
  output logic [issue_pkg::xlen-1:0]           rdata_b
);

  logic [issue_pkg::xlen-1:0] regs [2**issue_pkg::reg_addr_width];

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < 2**issue_pkg::reg_addr_width; i++) begin
        regs[i] <= '0;
      end
    end else if (we && waddr != '0) begin
      regs[waddr] <= wdata;
    end
  end

  // x0 always reads as zero whatever the array holds.
  always_comb begin
    if (raddr_a == '0) begin
      rdata_a = '0;
    end else begin
      rdata_a = regs[raddr_a];
    end
  end

  always_comb begin
    if (raddr_b == '0) begin
      rdata_b = '0;
    end else begin
      rdata_b = regs[raddr_b];
    end
  end

endmodule

// File: source/issue_pkg.sv
package issue_pkg;

  localparam int xlen = 32;
  localparam int reg_addr_width = 5;
  localparam int sb_depth = 4;
  localparam int tag_width = 2;
  localparam int wb_ports = 2;

  // Wide enough to hold 0 through sb_depth.
  localparam int sb_count_width = 3;

  typedef enum logic [1:0] {
    fu_alu = 2'd0,
    fu_mdu = 2'd1,
    fu_lsu = 2'd2
  } fu_e;

  // Decoded micro-op as it arrives from the decoder.
  typedef struct packed {
    logic [xlen-1:0]           pc;
    fu_e                       fu;
    logic [3:0]                op;
    logic [reg_addr_width-1:0] rs1;
    logic [reg_addr_width-1:0] rs2;
    logic [reg_addr_width-1:0] rd;
    logic                      use_rs1;
    logic                      use_rs2;
    logic                      we;      // Writes rd on retire.
    logic [xlen-1:0]           imm;
  } uop_t;

  // Request as seen by all three functional units.
  typedef struct packed {
    logic [tag_width-1:0] tag;
    fu_e                  fu;
    logic [3:0]           op;
    logic [xlen-1:0]      rs1_data;
    logic [xlen-1:0]      rs2_data;
    logic [xlen-1:0]      imm;
    logic [xlen-1:0]      pc;
  } fu_req_t;

  typedef struct packed {
    logic                 valid;
    logic [tag_width-1:0] tag;
    logic [xlen-1:0]      data;
  } writeback_t;

  // Busy means a writer is in flight without a result. Hit means data is valid.
  typedef struct packed {
    logic            busy;
    logic            hit;
    logic [xlen-1:0] data;
  } operand_t;

  typedef struct packed {
    logic [xlen-1:0]           pc;
    logic [reg_addr_width-1:0] rd;
    logic                      we;
    logic [xlen-1:0]           wdata;
  } retire_t;

  typedef struct packed {
    logic                      valid;
    logic                      done;   // Result has been written back.
    logic [reg_addr_width-1:0] rd;
    logic                      we;
    logic [xlen-1:0]           pc;
    logic [xlen-1:0]           data;
  } sb_entry_t;

endpackage
